//--- include/mont_consts.svh
`ifndef MONT_CONSTS_SVH
`define MONT_CONSTS_SVH

// Operand width N of the multiplier
// a, b, m and the result all use this width
`define MONT_WIDTH 1024

// Accumulator and adder width
// The running sum stays below 4m, so two extra bits are enough
`define ADD_WIDTH (`MONT_WIDTH + 2)

// Zero bits that pad an operand up to the adder width
`define PAD_WIDTH (`ADD_WIDTH - `MONT_WIDTH)

`endif

//--- hdl/montPkg.sv
`include "mont_consts.svh"

package montPkg;

  // Operands of one multiplication
  // The caller guarantees an odd m and a, b below m
  typedef struct packed {
    logic [`MONT_WIDTH-1:0] a;
    logic [`MONT_WIDTH-1:0] b;
    logic [`MONT_WIDTH-1:0] m;
  } montJob;

  // Unreduced result handed to the final stage
  // c is below 2m and m travels along for the last subtraction
  typedef struct packed {
    logic [`ADD_WIDTH-1:0]  c;
    logic [`MONT_WIDTH-1:0] m;
  } montPartial;

  // Stage states
  // addB and addM alternate for every bit of a
  // subtract is the adder cycle of the final stage
  typedef enum logic [1:0] {
    idle,
    addB,
    addM,
    subtract
  } iterState;

endpackage

//--- hdl/arithPkg.sv
`include "mont_consts.svh"

package arithPkg;

  // Adder operation
  typedef enum logic {
    opAdd,
    opSub
  } addOp;

  // Registered adder output
  // carry is the carry of an add or the borrow of a subtract
  typedef struct packed {
    logic                  carry;
    logic [`ADD_WIDTH-1:0] value;
  } addResult;

endpackage

//--- hdl/mpAdder.sv
`timescale 1ns/1ps
`include "mont_consts.svh"

module mpAdder (
  input  logic                  clk,
  input  logic                  resetn,
  input  arithPkg::addOp        op,
  input  logic [`ADD_WIDTH-1:0] x,
  input  logic [`ADD_WIDTH-1:0] y,
  output arithPkg::addResult    sum
);

  import arithPkg::*;

  // One extra bit on top catches carry or borrow
  logic [`ADD_WIDTH:0] wide;

  always_comb begin
    if (op == opSub) begin
      wide = {1'b0, x} - {1'b0, y};
    end else begin
      wide = {1'b0, x} + {1'b0, y};
    end
  end

  // Result is registered every cycle
  always_ff @(posedge clk) begin
    if (!resetn) begin
      sum <= '0;
    end else begin
      sum.carry <= wide[`ADD_WIDTH];
      sum.value <= wide[`ADD_WIDTH-1:0];
    end
  end

endmodule

//--- hdl/operandLoad.sv
`timescale 1ns/1ps
`include "mont_consts.svh"

module operandLoad (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   start,
  input  logic [`MONT_WIDTH-1:0] a,
  input  logic [`MONT_WIDTH-1:0] b,
  input  logic [`MONT_WIDTH-1:0] m,
  input  logic                   take,
  output logic                   ready,
  output montPkg::montJob        job,
  output logic                   jobValid
);

  import montPkg::*;

  // One-entry job buffer
  logic   full;
  montJob held;

  // A new job is accepted only into an empty buffer
  logic accept;

  assign accept   = start && !full;
  assign ready    = !full;
  assign jobValid = full;
  assign job      = held;

  // Occupancy flag
  // start and take never meet since take needs a full buffer
  always_ff @(posedge clk) begin
    if (!resetn) begin
      full <= 1'b0;
    end else if (accept) begin
      full <= 1'b1;
    end else if (take) begin
      full <= 1'b0;
    end
  end

  // Operand capture
  always_ff @(posedge clk) begin
    if (accept) begin
      held <= '{a: a, b: b, m: m};
    end
  end

endmodule

//--- hdl/montIterate.sv
`timescale 1ns/1ps
`include "mont_consts.svh"

module montIterate (
  input  logic                clk,
  input  logic                resetn,
  input  montPkg::montJob     job,
  input  logic                jobValid,
  output logic                take,
  output montPkg::montPartial partial,
  output logic                partialValid
);

  import montPkg::*;
  import arithPkg::*;

  localparam int countBits = $clog2(`MONT_WIDTH);
  localparam logic [countBits-1:0] lastBit = countBits'(`MONT_WIDTH - 1);

  iterState             state;
  logic [countBits-1:0] bitCount;

  // Operands of the job in flight
  logic [`MONT_WIDTH-1:0] aShift;
  logic [`MONT_WIDTH-1:0] bReg;
  logic [`MONT_WIDTH-1:0] mReg;

  // Adder inputs and registered output
  logic [`ADD_WIDTH-1:0] addX;
  logic [`ADD_WIDTH-1:0] addY;
  addResult              sum;

  // Accumulator C
  // The halving of each addM sum is just a shifted view of the adder register
  logic [`ADD_WIDTH-1:0] acc;

  assign acc  = {1'b0, sum.value[`ADD_WIDTH-1:1]};
  assign take = (state == idle) && jobValid;

  // Operand select per step
  // Idle adds zero so the adder holds zero when a job is taken
  always_comb begin
    case (state)
      addB: begin
        addX = acc;
        addY = aShift[0] ? {{`PAD_WIDTH{1'b0}}, bReg} : '0;
      end
      addM: begin
        addX = sum.value;
        addY = sum.value[0] ? {{`PAD_WIDTH{1'b0}}, mReg} : '0;
      end
      default: begin
        addX = '0;
        addY = '0;
      end
    endcase
  end

  mpAdder adder (
    .clk    (clk),
    .resetn (resetn),
    .op     (opAdd),
    .x      (addX),
    .y      (addY),
    .sum    (sum)
  );

  // Two cycles per bit of a
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state        <= idle;
      bitCount     <= '0;
      partialValid <= 1'b0;
    end else begin
      partialValid <= 1'b0;
      case (state)
        idle: begin
          if (take) begin
            state    <= addB;
            bitCount <= '0;
          end
        end
        addB: begin
          state <= addM;
        end
        addM: begin
          if (bitCount == lastBit) begin
            state        <= idle;
            partialValid <= 1'b1;
          end else begin
            bitCount <= bitCount + 1'b1;
            state    <= addB;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // Job copy on take, then a moves one bit per addM
  always_ff @(posedge clk) begin
    if (take) begin
      aShift <= job.a;
      bReg   <= job.b;
      mReg   <= job.m;
    end else if (state == addM) begin
      aShift <= aShift >> 1;
    end
  end

  // Valid in the idle cycle after the last addM
  assign partial = '{c: acc, m: mReg};

endmodule

//--- hdl/finalReduce.sv
`timescale 1ns/1ps
`include "mont_consts.svh"

module finalReduce (
  input  logic                   clk,
  input  logic                   resetn,
  input  montPkg::montPartial    partial,
  input  logic                   partialValid,
  output logic [`MONT_WIDTH-1:0] result,
  output logic                   done
);

  import montPkg::*;
  import arithPkg::*;

  iterState state;
  logic     checkNow;

  // Latched partial result and modulus
  logic [`ADD_WIDTH-1:0]  cHold;
  logic [`MONT_WIDTH-1:0] mHold;
  addResult               diff;

  // Computes c minus m
  // A borrow means c was already below m
  mpAdder subtractor (
    .clk    (clk),
    .resetn (resetn),
    .op     (opSub),
    .x      (cHold),
    .y      ({{`PAD_WIDTH{1'b0}}, mHold}),
    .sum    (diff)
  );

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state    <= idle;
      checkNow <= 1'b0;
      done     <= 1'b0;
      result   <= '0;
    end else begin
      checkNow <= 1'b0;
      done     <= 1'b0;
      case (state)
        idle: begin
          if (partialValid) begin
            state <= subtract;
          end
        end
        subtract: begin
          state    <= idle;
          checkNow <= 1'b1;
        end
        default: begin
          state <= idle;
        end
      endcase
      // Pick the value below m
      if (checkNow) begin
        result <= diff.carry ? cHold[`MONT_WIDTH-1:0] : diff.value[`MONT_WIDTH-1:0];
        done   <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if ((state == idle) && partialValid) begin
      cHold <= partial.c;
      mHold <= partial.m;
    end
  end

endmodule

//--- hdl/montMulTop.sv
`timescale 1ns/1ps
`include "mont_consts.svh"

module montMulTop (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   start,
  input  logic [`MONT_WIDTH-1:0] a,
  input  logic [`MONT_WIDTH-1:0] b,
  input  logic [`MONT_WIDTH-1:0] m,
  output logic                   ready,
  output logic [`MONT_WIDTH-1:0] result,
  output logic                   done
);

  import montPkg::*;

  // Load to iterate
  montJob job;
  logic   jobValid;
  logic   take;

  // Iterate to reduce
  montPartial partial;
  logic       partialValid;

  operandLoad loadStage (
    .clk      (clk),
    .resetn   (resetn),
    .start    (start),
    .a        (a),
    .b        (b),
    .m        (m),
    .take     (take),
    .ready    (ready),
    .job      (job),
    .jobValid (jobValid)
  );

  montIterate iterStage (
    .clk          (clk),
    .resetn       (resetn),
    .job          (job),
    .jobValid     (jobValid),
    .take         (take),
    .partial      (partial),
    .partialValid (partialValid)
  );

  finalReduce reduceStage (
    .clk          (clk),
    .resetn       (resetn),
    .partial      (partial),
    .partialValid (partialValid),
    .result       (result),
    .done         (done)
  );

endmodule

//--- verification/montMul_assert.sv
`timescale 1ns/1ps

module montMulAssert (
  input logic clk,
  input logic resetn,
  input logic jobValid,
  input logic take,
  input logic partialValid,
  input logic done
);

  // Failure counts for the testbench
  int unsigned doneFails = 0;
  int unsigned reduceFails = 0;
  int unsigned holdFails = 0;
  int unsigned failures;

  assign failures = doneFails + reduceFails + holdFails;

  // done is a single-cycle pulse
  doneIsPulse: assert property (@(posedge clk) disable iff (!resetn) done |=> !done)
    else begin
      $error("done stayed high for two cycles");
      doneFails = doneFails + 1;
    end

  // Final stage takes three cycles from partialValid to done
  reduceToDone: assert property (@(posedge clk) disable iff (!resetn)
    partialValid |-> ##3 done)
    else begin
      $error("done did not follow partialValid after three cycles");
      reduceFails = reduceFails + 1;
    end

  // A waiting job stays offered until the iteration stage takes it
  jobHeld: assert property (@(posedge clk) disable iff (!resetn)
    (jobValid && !take) |=> jobValid)
    else begin
      $error("jobValid dropped before take");
      holdFails = holdFails + 1;
    end

endmodule

bind montMulTop montMulAssert protocolChecks (
  .clk          (clk),
  .resetn       (resetn),
  .jobValid     (jobValid),
  .take         (take),
  .partialValid (partialValid),
  .done         (done)
);

//--- verification/montMulTb.sv
`timescale 1ns/1ps
`include "mont_consts.svh"

module montMulTb;

  import montPkg::*;

  localparam int width = `MONT_WIDTH;
  localparam int jobLatency = 2 * `MONT_WIDTH + 4;
  localparam int queueSpacing = 2 * `MONT_WIDTH + 1;
  localparam int randomJobs = 40;
  // Single, four edge cases, queued pair, ignored start, random run
  localparam int totalJobs = 1 + 4 + 2 + 1 + randomJobs;
  localparam int cycleLimit = totalJobs * jobLatency + 200;
  localparam logic [width-1:0] wideOne = {{(width-1){1'b0}}, 1'b1};

  logic             clk;
  logic             resetn;
  logic             start;
  logic [width-1:0] a;
  logic [width-1:0] b;
  logic [width-1:0] m;
  logic             ready;
  logic [width-1:0] result;
  logic             done;

  integer seed;
  int     cycle = 0;
  string  testName = "resetState";

  // Accepted jobs in order and the edge that sampled each start
  montJob expected[$];
  int     startCycles[$];
  int     doneCycles[$];

  montMulTop DUT (
    .clk    (clk),
    .resetn (resetn),
    .start  (start),
    .a      (a),
    .b      (b),
    .m      (m),
    .ready  (ready),
    .result (result),
    .done   (done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stopRun(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  // Cycle count and run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= cycleLimit) begin
      stopRun("Timeout: the jobs did not finish within the cycle limit");
    end
  end

  // Steps to 1 ns after a later rising edge
  task automatic nextCycle(input int count);
    repeat (count) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic randomWide(output logic [width-1:0] v);
    int i;
    v = '0;
    for (i = 0; i < width / 32; i++) begin
      v = {v[width-33:0], $random(seed)};
    end
  endtask

  // Odd m with the top bit set and a, b reduced below m
  task automatic randomJob(output logic [width-1:0] ja, output logic [width-1:0] jb,
                           output logic [width-1:0] jm);
    randomWide(jm);
    jm[width-1] = 1'b1;
    jm[0] = 1'b1;
    randomWide(ja);
    ja = ja % jm;
    randomWide(jb);
    jb = jb % jm;
  endtask

  task automatic driveStart(input logic [width-1:0] ja, input logic [width-1:0] jb,
                            input logic [width-1:0] jm);
    montJob job;
    // The buffer drops a start while it is full
    if (ready) begin
      job.a = ja;
      job.b = jb;
      job.m = jm;
      expected.push_back(job);
      startCycles.push_back(cycle + 1);
    end
    start = 1'b1;
    a = ja;
    b = jb;
    m = jm;
    nextCycle(1);
    start = 1'b0;
  endtask

  task automatic waitForDone(input int target);
    while (doneCycles.size() < target) begin
      nextCycle(1);
    end
  endtask

  task automatic checkLatency(input int index, input int want);
    int got;
    got = doneCycles[index] - startCycles[index];
    assert (got == want)
      else stopRun($sformatf("[ERROR] %s: latency expected %0d actual %0d", testName, want, got));
  endtask

  // Result times 2^N must match a times b, both mod m
  task automatic checkResult();
    montJob           job;
    logic [2*width-1:0] wideM;
    logic [2*width-1:0] wantMod;
    logic [2*width-1:0] gotMod;
    assert (expected.size() > 0)
      else stopRun($sformatf("%s: a done pulse arrived with no job outstanding", testName));
    job = expected.pop_front();
    wideM = {{width{1'b0}}, job.m};
    wantMod = ({{width{1'b0}}, job.a} * {{width{1'b0}}, job.b}) % wideM;
    gotMod = {result, {width{1'b0}}} % wideM;
    assert (result < job.m)
      else stopRun($sformatf("[ERROR] %s: result below m expected, m %0h actual %0h",
                             testName, job.m, result));
    assert (gotMod == wantMod)
      else stopRun($sformatf("[ERROR] %s: expected %0h actual %0h", testName, wantMod, gotMod));
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (resetn && done) begin
      doneCycles.push_back(cycle);
      checkResult();
    end
    assert (DUT.protocolChecks.failures == 0)
      else stopRun("A protocol assertion on the DUT failed");
  end

  task automatic runIdleJob(input logic [width-1:0] ja, input logic [width-1:0] jb,
                            input logic [width-1:0] jm);
    int base;
    base = startCycles.size();
    assert (ready) else stopRun($sformatf("%s: ready was low on an idle pipeline", testName));
    driveStart(ja, jb, jm);
    waitForDone(base + 1);
    checkLatency(base, jobLatency);
  endtask

  initial begin
    logic [width-1:0] ja;
    logic [width-1:0] jb;
    logic [width-1:0] jm;
    int n;
    int gap;
    int base;
    int spacing;

    seed = 32'h07f2e373;
    resetn = 1'b0;
    start = 1'b0;
    a = '0;
    b = '0;
    m = '0;
    repeat (5) @(posedge clk);
    #1;
    resetn = 1'b1;

    assert (ready === 1'b1)
      else stopRun($sformatf("[ERROR] %s: ready expected 1 actual %b", testName, ready));
    assert (done === 1'b0)
      else stopRun($sformatf("[ERROR] %s: done expected 0 actual %b", testName, done));
    assert (result === '0)
      else stopRun($sformatf("[ERROR] %s: result expected 0 actual %0h", testName, result));

    testName = "singleJob";
    randomJob(ja, jb, jm);
    runIdleJob(ja, jb, jm);

    testName = "edgeOperands";
    for (n = 0; n < 4; n++) begin
      randomJob(ja, jb, jm);
      case (n)
        0: ja = '0;
        1: jb = '0;
        2: ja = wideOne;
        default: ja = jm - wideOne;
      endcase
      runIdleJob(ja, jb, jm);
    end

    // Second job waits in the buffer while the first iterates
    testName = "queuedJob";
    base = startCycles.size();
    randomJob(ja, jb, jm);
    driveStart(ja, jb, jm);
    nextCycle(4);
    assert (ready) else stopRun("queuedJob: ready was low while only one job was iterating");
    randomJob(ja, jb, jm);
    driveStart(ja, jb, jm);
    assert (!ready) else stopRun("queuedJob: ready stayed high with a job waiting");

    testName = "startWhileFull";
    randomJob(ja, jb, jm);
    driveStart(ja, jb, jm);
    assert (!ready)
      else stopRun("startWhileFull: ready rose while the buffered job was still waiting");
    waitForDone(base + 2);
    spacing = doneCycles[base + 1] - doneCycles[base];
    assert (spacing == queueSpacing)
      else stopRun($sformatf("[ERROR] queuedJob: done spacing expected %0d actual %0d",
                             queueSpacing, spacing));
    // A wrongly accepted third job would finish within this window
    nextCycle(queueSpacing + 3);
    assert (doneCycles.size() == base + 2)
      else stopRun("startWhileFull: an extra done pulse followed the ignored start");

    testName = "randomRun";
    for (n = 0; n < randomJobs; n++) begin
      randomJob(ja, jb, jm);
      gap = $random(seed) & 7;
      nextCycle(gap);
      while (!ready) begin
        nextCycle(1);
      end
      driveStart(ja, jb, jm);
    end
    waitForDone(startCycles.size());
    nextCycle(5);
    assert (doneCycles.size() == startCycles.size() && expected.size() == 0)
      else stopRun("randomRun: the number of done pulses does not match the accepted jobs");

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+include
hdl/montPkg.sv
hdl/arithPkg.sv
hdl/mpAdder.sv
hdl/operandLoad.sv
hdl/montIterate.sv
hdl/finalReduce.sv
hdl/montMulTop.sv
verification/montMul_assert.sv
verification/montMulTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the Montgomery multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -j 0 \
  -f filelist.f \
  --top-module montMulTb \
  -Mdir "$BUILD" -o montMulSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD/montMulSim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -qF "*** TEST FAILED ***" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if ! grep -qF "*** TEST PASSED ***" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
exit 0
